/* Makefile */
# Verilator simulation of the XT I/O glue, run from the project root

VERILATOR ?= verilator
TOP       ?= tb_xt_peripherals
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q -F '*** PASSED ***' $(LOG) || (echo "Simulation did not pass, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* ems_page_mapper.sv */
/*
 * EMS page registers with readback and upper-memory bank hits.
 * A page write lands two rising edges after io_write_n is sampled low.
 * Bytes 80h..FEh leave the addressed page unchanged.
 */
`timescale 1ns/10ps

module ems_page_mapper (
    input  logic                    clock,
    input  logic                    reset,
    input  xt_io_pkg::xt_bus_t      bus_i,
    input  logic                    ems_select_i,
    input  xt_io_pkg::ems_window_t  window_i,
    output logic [7:0]              read_data_o,
    output logic [3:0]              bank_hit_o
);
    import xt_io_pkg::*;

    ems_entry_t pages [EMS_PAGE_COUNT];

    // First stage of the write path
    logic       write_pending;
    logic [1:0] write_index;
    ems_entry_t write_entry;

    ems_entry_t current_entry;
    ems_entry_t next_entry;
    logic [3:0] window_base;
    logic       io_idle;

    // Disable, enable or keep depending on the written byte
    function automatic ems_entry_t encode_page_write(
        input logic [7:0] data,
        input ems_entry_t current
    );
        ems_entry_t result;
        if (data == EMS_DISABLE_CODE) begin
            result.enable = 1'b0;
            result.page   = 7'h7F;
        end else if (data < EMS_PAGE_LIMIT) begin
            result.enable = 1'b1;
            result.page   = data[6:0];
        end else begin
            result = current;
        end
        return result;
    endfunction

    assign current_entry = pages[bus_i.address[1:0]];
    assign next_entry    = encode_page_write(bus_i.write_data, current_entry);

    always_ff @(posedge clock, posedge reset) begin
        if (reset) begin
            write_pending <= 1'b0;
        end else begin
            write_pending <= ems_select_i & ~bus_i.io_write_n;
        end
    end

    always_ff @(posedge clock) begin
        write_index <= bus_i.address[1:0];
        write_entry <= next_entry;
    end

    // Second stage commits the captured entry
    always_ff @(posedge clock, posedge reset) begin
        if (reset) begin
            for (int i = 0; i < EMS_PAGE_COUNT; i++) begin
                pages[i] <= '{enable: 1'b0, page: 7'h00};
            end
        end else if (write_pending) begin
            pages[write_index] <= write_entry;
        end
    end

    // Disabled pages read back as FFh
    assign read_data_o = current_entry.enable ? {1'b0, current_entry.page}
                                              : EMS_DISABLE_CODE;

    always_comb begin
        case (window_i)
            WIN_A000: window_base = 4'hA;
            WIN_C000: window_base = 4'hC;
            default:  window_base = 4'hD;
        endcase
    end

    // Bank hits only while no I/O strobe is active
    assign io_idle = bus_i.io_read_n & bus_i.io_write_n;

    // Each page owns one 16 KB slot of the 64 KB frame
    always_comb begin
        for (int k = 0; k < EMS_PAGE_COUNT; k++) begin
            bank_hit_o[k] = io_idle && pages[k].enable
                            && (bus_i.address[19:14] == {window_base, 2'(k)});
        end
    end

endmodule

/* io_port_decoder.sv */
/*
 * Combinational I/O decode for the low page, EMS and LPT ports.
 * EMS_PORT_BASE must be aligned to 4 ports, LPT_PORT_BASE to 8.
 * Every select here is already qualified by an I/O strobe.
 */
`timescale 1ns/10ps

module io_port_decoder #(
    parameter logic [15:0] EMS_PORT_BASE = 16'h0260,
    parameter logic [15:0] LPT_PORT_BASE = 16'h0378
) (
    input  xt_io_pkg::xt_bus_t       bus_i,
    input  logic                     ems_enabled_i,
    output xt_io_pkg::chip_select_t  cs_o
);
    import xt_io_pkg::*;

    // Group numbers of the 32-port blocks below 100h
    localparam logic [LOW_IO_GROUP_BITS-1:0] GROUP_DMA       = 3'd0;
    localparam logic [LOW_IO_GROUP_BITS-1:0] GROUP_INTERRUPT = 3'd1;
    localparam logic [LOW_IO_GROUP_BITS-1:0] GROUP_TIMER     = 3'd2;
    localparam logic [LOW_IO_GROUP_BITS-1:0] GROUP_PPI       = 3'd3;
    localparam logic [LOW_IO_GROUP_BITS-1:0] GROUP_DMA_PAGE  = 3'd4;

    logic                         io_request;
    logic                         io_cycle;
    logic                         low_page;
    logic [LOW_IO_GROUP_BITS-1:0] group;

    // Either strobe counts, DMA cycles are excluded by AEN
    assign io_request = ~bus_i.io_read_n | ~bus_i.io_write_n;
    assign io_cycle   = io_request & ~bus_i.address_enable_n;

    assign low_page = io_cycle & ~bus_i.address[9] & ~bus_i.address[8];
    assign group    = bus_i.address[7:5];

    always_comb begin
        cs_o.dma_n       = ~(low_page && (group == GROUP_DMA));
        cs_o.interrupt_n = ~(low_page && (group == GROUP_INTERRUPT));
        cs_o.timer_n     = ~(low_page && (group == GROUP_TIMER));
        cs_o.ppi_n       = ~(low_page && (group == GROUP_PPI));
        cs_o.dma_page_n  = ~(low_page && (group == GROUP_DMA_PAGE));

        // Four page registers at the EMS base
        cs_o.ems_port = io_cycle && ems_enabled_i
                        && (bus_i.address[15:2] == EMS_PORT_BASE[15:2]);

        // Eight-port parallel block, only the data port is latched here
        cs_o.lpt_data = io_cycle
                        && (bus_i.address[15:3] == LPT_PORT_BASE[15:3]);
    end

endmodule

/* io_read_return.sv */
/*
 * Parallel-port data latch and the registered CPU read path.
 * Read data appears one rising edge after io_read_n is sampled low.
 * EMS readback wins over the LPT latch when both are selected.
 */
`timescale 1ns/10ps

module io_read_return (
    input  logic                     clock,
    input  logic                     reset,
    input  xt_io_pkg::xt_bus_t       bus_i,
    input  xt_io_pkg::chip_select_t  cs_i,
    input  logic [7:0]               ems_read_data_i,
    output logic [7:0]               data_bus_out_o,
    output logic                     data_from_chipset_o
);
    import xt_io_pkg::*;

    logic [7:0] lpt_byte;
    logic       read_cycle;
    logic [7:0] read_byte;
    logic       read_valid;

    // Printer data port, reads back the last byte written
    always_ff @(posedge clock, posedge reset) begin
        if (reset) begin
            lpt_byte <= IDLE_READ_BYTE;
        end else if (cs_i.lpt_data && !bus_i.io_write_n) begin
            lpt_byte <= bus_i.write_data;
        end
    end

    assign read_cycle = ~bus_i.io_read_n;

    // Fixed priority among the chipset sources
    always_comb begin
        if (read_cycle && cs_i.ems_port) begin
            read_byte  = ems_read_data_i;
            read_valid = 1'b1;
        end else if (read_cycle && cs_i.lpt_data) begin
            read_byte  = lpt_byte;
            read_valid = 1'b1;
        end else begin
            read_byte  = 8'h00;
            read_valid = 1'b0;
        end
    end

    // Nothing from here drives the bus when no source matched
    always_ff @(posedge clock, posedge reset) begin
        if (reset) begin
            data_bus_out_o      <= 8'h00;
            data_from_chipset_o <= 1'b0;
        end else begin
            data_bus_out_o      <= read_byte;
            data_from_chipset_o <= read_valid;
        end
    end

endmodule

/* stim_vectors.txt */
# op  address  data  expect  check   (address, data and expect in hex)
# CFG takes ems_enabled_i from the address and ems_window_i from the data
# cs and bank are checked while the strobe is driven, rd and vld one edge later
IDL 00000 00 0  vld
CFG 00001 01 0  none
MEM C0000 00 0  bank
IOR 00260 00 FF rd
IOR 00260 00 7E cs
IOR 00000 00 3C cs
IOR 00020 00 6C cs
IOR 00040 00 74 cs
IOR 00060 00 78 cs
IOR 00080 00 5C cs
IOA 00000 00 7C cs
IOA 00020 00 7C cs
IOA 00040 00 7C cs
IOA 00060 00 7C cs
IOA 00080 00 7C cs
IOR 00100 00 7C cs
IOR 00120 00 7C cs
IOR 00140 00 7C cs
IOR 00160 00 7C cs
IOR 00180 00 7C cs
IOW 00261 05 0  none
IOR 00261 00 05 rd
IOW 00261 90 0  none
IOR 00261 00 05 rd
IOW 00261 FF 0  none
IOR 00261 00 FF rd
IOW 00262 03 0  none
IOR 00262 00 03 rd
MEM C8000 00 4  bank
MEM C4000 00 0  bank
MEM CC000 00 0  bank
IOR C8000 00 0  bank
IOW C8000 00 0  bank
CFG 00001 00 0  none
MEM A8000 00 4  bank
MEM C8000 00 0  bank
CFG 00001 03 0  none
MEM D8000 00 4  bank
CFG 00000 01 0  none
IOR 00260 00 0  vld
IOW 00261 07 0  none
CFG 00001 01 0  none
IOR 00261 00 FF rd
IOW 00262 FF 0  none
MEM C8000 00 0  bank
IOR 00378 00 FF rd
IOW 00378 A5 0  none
IOR 00378 00 A5 rd
IOR 0037A 00 A5 rd
IOR 00300 00 0  vld
IOR 00378 00 1  vld

/* tb.f */
xt_io_pkg.sv
io_port_decoder.sv
ems_page_mapper.sv
io_read_return.sv
xt_peripherals.sv
tb_xt_peripherals.sv

/* tb_xt_peripherals.sv */
/*
 * Testbench for xt_peripherals, driven line by line from stim_vectors.txt.
 * Run from the project root so that the stimulus path resolves.
 * Bus inputs change on the falling edge and checks follow the fixed latencies.
 */
`timescale 1ns/10ps

module tb_xt_peripherals;
    import xt_io_pkg::*;

    localparam string       STIM_FILE    = "stim_vectors.txt";
    localparam logic [31:0] RANDOM_SEED  = 32'h7049db0f;
    localparam int          READ_TIMEOUT = 4;
    localparam int          MAX_LINES    = 1000;

    logic         clock;
    logic         reset;
    xt_bus_t      bus;
    logic         ems_enabled;
    ems_window_t  ems_window;
    chip_select_t cs;
    logic [3:0]   ems_bank;
    logic [7:0]   data_bus_out;
    logic         data_from_chipset;

    int mismatch_count;
    int timeout_count;
    int other_error_count;
    int vector_count;

    xt_peripherals #(
        .EMS_PORT_BASE (16'h0260),
        .LPT_PORT_BASE (16'h0378)
    ) u_xt_peripherals (
        .clock               (clock),
        .reset               (reset),
        .bus_i               (bus),
        .ems_enabled_i       (ems_enabled),
        .ems_window_i        (ems_window),
        .cs_o                (cs),
        .ems_bank_o          (ems_bank),
        .data_bus_out_o      (data_bus_out),
        .data_from_chipset_o (data_from_chipset)
    );

    always #2 clock = ~clock;

    // Strobes released and AEN low with random write data
    function automatic xt_bus_t idle_bus();
        xt_bus_t result;
        result.address          = 20'h00000;
        result.write_data       = 8'($urandom());
        result.io_read_n        = 1'b1;
        result.io_write_n       = 1'b1;
        result.memory_read_n    = 1'b1;
        result.address_enable_n = 1'b0;
        return result;
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            mismatch_count++;
            $display("MISMATCH %s: expected %0h, actual %0h", name, expected, actual);
        end
    endtask

    // From one falling edge across a rising edge to the next falling edge
    task automatic advance_edge();
        @(posedge clock);
        @(negedge clock);
    endtask

    // One bus operation between two falling edges
    task automatic execute_vector(input string op, input logic [19:0] address,
                                  input logic [7:0] data, input logic [31:0] expected,
                                  input string what, input string name);
        xt_bus_t next_bus;
        int      latency;
        next_bus = idle_bus();
        if (op == "IOW") begin
            next_bus.address    = address;
            next_bus.write_data = data;
            next_bus.io_write_n = 1'b0;
        end else if (op == "IOR" || op == "IOA") begin
            next_bus.address   = address;
            next_bus.io_read_n = 1'b0;
            // IOA is a read during a DMA cycle
            next_bus.address_enable_n = (op == "IOA");
        end else if (op == "MEM") begin
            next_bus.address       = address;
            next_bus.memory_read_n = 1'b0;
        end else if (op == "CFG") begin
            ems_enabled = address[0];
            ems_window  = ems_window_t'(data[1:0]);
        end else if (op != "IDL") begin
            other_error_count++;
            $display("ERROR: %s uses an unknown operation", name);
        end
        bus = next_bus;

        // Combinational selects and bank hits are sampled mid-cycle
        #1;
        if (what == "cs") begin
            check_value(name, expected, 32'(cs));
        end else if (what == "bank") begin
            check_value(name, expected, 32'(ems_bank));
        end
        advance_edge();
        bus = idle_bus();

        if (what == "rd") begin
            latency = 1;
            while (!data_from_chipset && latency < READ_TIMEOUT) begin
                advance_edge();
                latency++;
            end
            if (!data_from_chipset) begin
                timeout_count++;
                $display("TIMEOUT: %s got no read data within %0d clock edges",
                         name, latency);
            end else begin
                check_value({name, " latency"}, 32'd1, 32'(latency));
                check_value(name, expected, 32'(data_bus_out));
            end
        end else if (what == "vld") begin
            check_value(name, expected, 32'(data_from_chipset));
            // An unclaimed read returns 00h
            if (expected == 32'd0) begin
                check_value({name, " data"}, 32'h00, 32'(data_bus_out));
            end
        end else if (what != "cs" && what != "bank" && what != "none") begin
            other_error_count++;
            $display("ERROR: %s names an unknown check", name);
        end

        // Page registers commit on the second edge
        if (op == "IOW") begin
            advance_edge();
        end
    endtask

    initial begin
        int          stim_fd;
        int          line_no;
        int          fields;
        string       text;
        string       op;
        string       what;
        string       name;
        logic [19:0] address;
        logic [7:0]  data;
        logic [31:0] expected;

        void'($urandom(RANDOM_SEED));
        mismatch_count    = 0;
        timeout_count     = 0;
        other_error_count = 0;
        vector_count      = 0;
        line_no           = 0;
        clock             = 1'b0;
        reset             = 1'b1;
        bus               = idle_bus();
        ems_enabled       = 1'b0;
        ems_window        = WIN_C000;

        repeat (2) @(posedge clock);
        @(negedge clock);
        reset = 1'b0;

        stim_fd = $fopen(STIM_FILE, "r");
        if (stim_fd == 0) begin
            other_error_count++;
            $display("ERROR: cannot open the stimulus file %s", STIM_FILE);
        end else begin
            while (line_no < MAX_LINES && $fgets(text, stim_fd) > 0) begin
                line_no++;
                fields = $sscanf(text, "%s %h %h %h %s", op, address, data, expected, what);
                // Blank and comment lines
                if (fields <= 0) begin
                    continue;
                end
                if (op.substr(0, 0) == "#") begin
                    continue;
                end
                if (fields != 5) begin
                    other_error_count++;
                    $display("ERROR: line %0d of the stimulus file is malformed", line_no);
                    continue;
                end
                name = $sformatf("line %0d %s %s", line_no, op, what);
                execute_vector(op, address, data, expected, what, name);
                vector_count++;
            end
            $fclose(stim_fd);
        end
        if (vector_count == 0) begin
            other_error_count++;
            $display("ERROR: no vectors were run");
        end

        $display("Vectors %0d, mismatches %0d, timeouts %0d, other errors %0d",
                 vector_count, mismatch_count, timeout_count, other_error_count);
        if (mismatch_count + timeout_count + other_error_count == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

/* xt_io_pkg.sv */
/*
 * Shared bus, chip-select and EMS types for the XT I/O glue.
 * Only the low 16 address bits take part in I/O decode.
 * Window code 3 is treated as the D000 window.
 */
package xt_io_pkg;

    // CPU side of the bus, sampled once per clock
    typedef struct packed {
        logic [19:0] address;
        logic [7:0]  write_data;
        logic        io_read_n;
        logic        io_write_n;
        logic        memory_read_n;
        logic        address_enable_n;
    } xt_bus_t;

    // Low-page selects for the external chips stay active low
    typedef struct packed {
        logic dma_n;
        logic dma_page_n;
        logic interrupt_n;
        logic timer_n;
        logic ppi_n;
        logic ems_port;
        logic lpt_data;
    } chip_select_t;

    // Upper-memory base of the EMS frame
    typedef enum logic [1:0] {
        WIN_A000 = 2'd0,
        WIN_C000 = 2'd1,
        WIN_D000 = 2'd2
    } ems_window_t;

    // One page register
    typedef struct packed {
        logic       enable;
        logic [6:0] page;
    } ems_entry_t;

    localparam int EMS_PAGE_COUNT = 4;

    // Width of the 32-port group field in address bits 7..5
    localparam int LOW_IO_GROUP_BITS = 3;

    // Page-write codes
    localparam logic [7:0] EMS_DISABLE_CODE = 8'hFF;
    localparam logic [7:0] EMS_PAGE_LIMIT   = 8'h80;

    // Value of an unwritten data latch
    localparam logic [7:0] IDLE_READ_BYTE = 8'hFF;

endpackage

/* xt_peripherals.sv */
/*
 * XT I/O glue: port decode, EMS page mapper and CPU read return.
 * The DMA, PIC, PIT and PPI chips are external and use cs_o.
 * EMS base aligned to 4 ports, LPT base aligned to 8 ports.
 */
`timescale 1ns/10ps

module xt_peripherals #(
    parameter logic [15:0] EMS_PORT_BASE = 16'h0260,
    parameter logic [15:0] LPT_PORT_BASE = 16'h0378
) (
    input  logic                     clock,
    input  logic                     reset,
    input  xt_io_pkg::xt_bus_t       bus_i,
    input  logic                     ems_enabled_i,
    input  xt_io_pkg::ems_window_t   ems_window_i,
    output xt_io_pkg::chip_select_t  cs_o,
    output logic [3:0]               ems_bank_o,
    output logic [7:0]               data_bus_out_o,
    output logic                     data_from_chipset_o
);

    // Page readback for the current port address
    logic [7:0] ems_read_data;

    io_port_decoder #(
        .EMS_PORT_BASE (EMS_PORT_BASE),
        .LPT_PORT_BASE (LPT_PORT_BASE)
    ) u_io_port_decoder (
        .bus_i         (bus_i),
        .ems_enabled_i (ems_enabled_i),
        .cs_o          (cs_o)
    );

    ems_page_mapper u_ems_page_mapper (
        .clock        (clock),
        .reset        (reset),
        .bus_i        (bus_i),
        .ems_select_i (cs_o.ems_port),
        .window_i     (ems_window_i),
        .read_data_o  (ems_read_data),
        .bank_hit_o   (ems_bank_o)
    );

    io_read_return u_io_read_return (
        .clock               (clock),
        .reset               (reset),
        .bus_i               (bus_i),
        .cs_i                (cs_o),
        .ems_read_data_i     (ems_read_data),
        .data_bus_out_o      (data_bus_out_o),
        .data_from_chipset_o (data_from_chipset_o)
    );

endmodule
